// ==== Makefile ====
# Verilator build and run for the lamb latch-array FIFO

TOP := lamb_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f lamb.f

# the run passes only when the simulation printed the pass message
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f lamb.f

clean:
	rm -rf obj_dir

// ==== bench/lamb_checker.sv ====
// --------------------------------------------------
// lamb checker
// scoreboard on the FIFO ports, checks order, data,
// first-word latency and both credit loops
// --------------------------------------------------

`timescale 1ns/10ps

`include "lamb_cfg.svh"

module lamb_checker (
   input  logic            ck,
   input  logic            rst_n,
   input  logic            in_valid,
   input  lamb_pkg::word_t in_data,
   input  logic            in_credit,
   input  logic            out_valid,
   input  lamb_pkg::word_t out_data,
   input  logic            out_credit,
   // end of a test, with its number and word count
   input  logic            test_end,
   input  int              test_id,
   input  int              test_words,
   output int              errors,
   output int              checks,
   output logic            drained
);

   import lamb_pkg::*;

   // words in flight, and the acceptance cycle of each or -1 when its latency is free
   word_t sent_q[$];
   int    acc_q[$];
   word_t exp_w;
   int    acc;
   int    cycle;
   // credits held by the sender and by the FIFO for the receiver
   int    tx_cr;
   int    rx_cr;
   int    err_cnt;
   int    chk_cnt;
   // per test counts
   int    t_in;
   int    t_out;
   int    t_err;
   int    peak;
   bit    written;
   bit    idle;

   task automatic report_mismatch(input string msg);
      $display("mismatch at %0t: %s", $time, msg);
      err_cnt++;
      t_err++;
   endtask

   task automatic report_error(input string msg);
      $display("error at %0t: %s", $time, msg);
      err_cnt++;
      t_err++;
   endtask

   always @(posedge ck) begin
      if (!rst_n) begin
         sent_q.delete();
         acc_q.delete();
         cycle   = 0;
         tx_cr   = `LAMB_DEPTH;
         rx_cr   = `LAMB_OUT_CREDITS;
         err_cnt = 0;
         chk_cnt = 0;
         t_in    = 0;
         t_out   = 0;
         t_err   = 0;
         peak    = 0;
         written = 1'b0;
         errors  <= 0;
         checks  <= 0;
         drained <= 1'b1;
      end else begin
         cycle++;
         // an empty FIFO with a receiver credit gives the fixed latency
         idle = (sent_q.size() == 0) && (rx_cr > 0);
         if (!written && (out_valid || in_credit)) begin
            report_error("out_valid or in_credit raised before any word was written");
         end
         if (out_valid) begin
            t_out++;
            rx_cr--;
            if (rx_cr < 0) begin
               report_error("out_valid raised with no receiver credit left");
            end
            if (sent_q.size() == 0) begin
               report_error("out_valid raised with no word outstanding");
            end else begin
               exp_w = sent_q.pop_front();
               acc   = acc_q.pop_front();
               chk_cnt++;
               if (out_data !== exp_w) begin
                  report_mismatch($sformatf("out_data %h, expected %h", out_data, exp_w));
               end
               // out_valid was registered one edge before it is seen here
               if (acc >= 0) begin
                  chk_cnt++;
                  if (cycle - 1 - acc != 3) begin
                     report_mismatch($sformatf("latency %0d, expected 3", cycle - 1 - acc));
                  end
               end
            end
         end
         if (in_valid) begin
            written = 1'b1;
            if (tx_cr == 0) begin
               report_error("in_valid raised by a sender that holds no credit");
            end
            tx_cr--;
            sent_q.push_back(in_data);
            acc_q.push_back(idle ? cycle : -1);
         end
         if (in_credit) begin
            t_in++;
            tx_cr++;
         end
         if (out_credit) begin
            rx_cr++;
         end
         // every word inside the FIFO holds exactly one sender credit
         if (sent_q.size() + tx_cr != `LAMB_DEPTH) begin
            report_mismatch($sformatf("%0d words held with %0d sender credits",
                                      sent_q.size(), tx_cr));
         end
         if (sent_q.size() > peak) begin
            peak = sent_q.size();
         end
         if (test_end) begin
            chk_cnt += 3;
            if (t_out != test_words) begin
               report_mismatch($sformatf("%0d words out, expected %0d", t_out, test_words));
            end
            if (t_in != t_out) begin
               report_mismatch($sformatf("%0d in_credit pulses for %0d words", t_in, t_out));
            end
            if (tx_cr != `LAMB_DEPTH) begin
               report_mismatch($sformatf("sender holds %0d credits after draining", tx_cr));
            end
            $display("test %0d done: %0d words, peak fill %0d, %0d errors",
                     test_id, t_out, peak, t_err);
            t_in  = 0;
            t_out = 0;
            t_err = 0;
            peak  = 0;
         end
         errors  <= err_cnt;
         checks  <= chk_cnt;
         drained <= (sent_q.size() == 0) && (tx_cr == `LAMB_DEPTH) &&
                    (rx_cr == `LAMB_OUT_CREDITS);
      end
   end

endmodule

// ==== bench/lamb_properties.sv ====
// --------------------------------------------------
// lamb properties
// strobe pair and credit assertions, bound into the
// FIFO top level
// --------------------------------------------------

`timescale 1ns/10ps

`include "lamb_cfg.svh"

module lamb_properties (
   input logic              ck,
   input logic              rst_n,
   input logic              in_valid,
   input logic              in_credit,
   input lamb_pkg::strobe_t wr_ck,
   input lamb_pkg::strobe_t wr_ckb,
   input lamb_pkg::strobe_t rd_rwl,
   input lamb_pkg::strobe_t rd_rwlb,
   input logic              rd_z
);

   // sender credits as seen at the FIFO ports
   int tx_cr;

   // failures per assertion, summed for the testbench
   int n_wr = 0;
   int n_rd = 0;
   int n_one = 0;
   int n_z = 0;
   int n_cr = 0;
   int fail_count;

   assign fail_count = n_wr + n_rd + n_one + n_z + n_cr;

   always @(posedge ck) begin
      if (!rst_n) begin
         tx_cr <= `LAMB_DEPTH;
      end else begin
         tx_cr <= tx_cr - int'(in_valid) + int'(in_credit);
      end
   end

   a_wr_pair: assert property (@(posedge ck) disable iff (!rst_n) wr_ck == ~wr_ckb)
      else begin
         n_wr++;
         $error("write strobe and its complement disagree");
      end

   a_rd_pair: assert property (@(posedge ck) disable iff (!rst_n) rd_rwl == ~rd_rwlb)
      else begin
         n_rd++;
         $error("read strobe and its complement disagree");
      end

   // only the head row may drive the shared column outputs
   a_rd_one: assert property (@(posedge ck) disable iff (!rst_n) $onehot0(rd_rwl))
      else begin
         n_one++;
         $error("more than one entry read at once");
      end

   a_rd_z: assert property (@(posedge ck) disable iff (!rst_n) rd_z == (rd_rwl == '0))
      else begin
         n_z++;
         $error("output force does not follow the read strobes");
      end

   a_credit: assert property (@(posedge ck) disable iff (!rst_n) in_valid |-> tx_cr > 0)
      else begin
         n_cr++;
         $error("sender wrote without a credit");
      end

endmodule

bind lamb_fifo lamb_properties u_props (
   .ck        (ck),
   .rst_n     (rst_n),
   .in_valid  (in_valid),
   .in_credit (in_credit),
   .wr_ck     (wr_ck),
   .wr_ckb    (wr_ckb),
   .rd_rwl    (rd_rwl),
   .rd_rwlb   (rd_rwlb),
   .rd_z      (rd_z)
);

// ==== bench/lamb_tb.sv ====
// --------------------------------------------------
// lamb testbench
// runs a table of tests through the FIFO with a
// credit based sender and a delayed receiver
// --------------------------------------------------

`timescale 1ns/10ps

`include "lamb_cfg.svh"

module lamb_tb;

   import lamb_pkg::*;

   // words sent, largest random gap between words, receiver consume delay
   typedef struct packed {
      int words;
      int max_gap;
      int rx_delay;
   } row_t;

   localparam int NTESTS = 5;
   localparam row_t TESTS [NTESTS] = '{
      '{20, 0, 0},
      '{24, 3, 1},
      // slow receiver, the sender refills until all entries are taken
      '{16, 0, 30},
      '{30, 2, 6},
      // sparse words that mostly meet an empty FIFO
      '{12, 6, 0}
   };

   logic  ck;
   logic  rst_n;
   logic  in_valid;
   word_t in_data;
   logic  in_credit;
   logic  out_valid;
   word_t out_data;
   logic  out_credit;
   logic  test_end;
   int    test_id;
   int    test_words;
   int    errors;
   int    checks;
   logic  drained;

   // sender and receiver model state
   int tx_credits = `LAMB_DEPTH;
   int tx_sent = 0;
   int tx_words = 0;
   int gap_left = 0;
   int max_gap = 0;
   int rx_delay = 0;
   int rx_due[$];
   int tb_cycle = 0;
   int cycle_cnt = 0;
   int limit_cycles = 0;

   lamb_fifo dut0 (
      .ck         (ck),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_credit (out_credit)
   );

   lamb_checker chk0 (
      .ck         (ck),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_credit (out_credit),
      .test_end   (test_end),
      .test_id    (test_id),
      .test_words (test_words),
      .errors     (errors),
      .checks     (checks),
      .drained    (drained)
   );

   initial ck = 1'b0;
   always #2 ck = ~ck;

   always @(posedge ck) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == limit_cycles) begin
         $display("timeout: the tests did not finish within %0d cycles", limit_cycles);
         $display("Test failed");
         $finish;
      end
   end

   // reset, idle time and a margin on top of the worst pace of every row
   function automatic int run_limit();
      int sum;
      sum = 16 + 200;
      for (int t = 0; t < NTESTS; t++) begin
         sum += TESTS[t].words * (TESTS[t].max_gap + TESTS[t].rx_delay + 6);
      end
      return sum;
   endfunction

   // one clock of sender and receiver, called right after a rising edge
   task automatic drive_cycle();
      tb_cycle++;
      if (in_credit) tx_credits++;
      // each word is consumed after the row's delay and its credit goes back
      if (out_valid) rx_due.push_back(tb_cycle + rx_delay);
      if (rx_due.size() > 0 && rx_due[0] <= tb_cycle) begin
         out_credit <= 1'b1;
         void'(rx_due.pop_front());
      end else begin
         out_credit <= 1'b0;
      end
      if (gap_left > 0) begin
         gap_left--;
         in_valid <= 1'b0;
      end else if (tx_sent < tx_words && tx_credits > 0) begin
         in_valid <= 1'b1;
         in_data  <= word_t'($urandom);
         tx_credits--;
         tx_sent++;
         gap_left = int'($urandom_range(max_gap, 0));
      end else begin
         in_valid <= 1'b0;
      end
   endtask

   initial begin
      void'($urandom(32'h9b26_7acb));
      rst_n        = 1'b0;
      in_valid     = 1'b0;
      in_data      = '0;
      out_credit   = 1'b0;
      test_end     = 1'b0;
      test_id      = 0;
      test_words   = 0;
      limit_cycles = run_limit();
      repeat (16) @(posedge ck);
      rst_n <= 1'b1;
      // a quiet stretch where nothing may come out
      repeat (8) begin
         @(posedge ck);
         drive_cycle();
      end
      for (int t = 0; t < NTESTS; t++) begin
         tx_words = TESTS[t].words;
         tx_sent  = 0;
         max_gap  = TESTS[t].max_gap;
         rx_delay = TESTS[t].rx_delay;
         gap_left = 0;
         while (tx_sent < tx_words) begin
            @(posedge ck);
            drive_cycle();
         end
         // let the last word reach the scoreboard before asking for drained
         repeat (2) begin
            @(posedge ck);
            drive_cycle();
         end
         while (!drained) begin
            @(posedge ck);
            drive_cycle();
         end
         test_id    <= t;
         test_words <= TESTS[t].words;
         test_end   <= 1'b1;
         @(posedge ck);
         drive_cycle();
         test_end <= 1'b0;
      end
      repeat (2) @(posedge ck);
      $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
               NTESTS, checks, errors, dut0.u_props.fail_count);
      if (errors == 0 && dut0.u_props.fail_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== lamb.f ====
+incdir+src
src/lamb_pkg.sv
src/latchblk.sv
src/lamb_array.sv
src/lamb_wr_ctrl.sv
src/lamb_rd_ctrl.sv
src/lamb_fifo.sv
bench/lamb_properties.sv
bench/lamb_checker.sv
bench/lamb_tb.sv

// ==== src/lamb_array.sv ====
// --------------------------------------------------
// lamb array
// storage of the FIFO, one latchblk column per bit
// of the word, all columns sharing the strobes
// --------------------------------------------------

`timescale 1ns/10ps

`include "lamb_cfg.svh"

module lamb_array (
   // write strobe pair, one bit per entry
   input  lamb_pkg::strobe_t wr_ck,
   input  lamb_pkg::strobe_t wr_ckb,
   // read strobe pair, one bit per entry
   input  lamb_pkg::strobe_t rd_rwl,
   input  lamb_pkg::strobe_t rd_rwlb,
   // inverted write word
   input  lamb_pkg::word_t   wr_dx,
   // read output force low
   input  logic              rd_z,
   // read word
   output lamb_pkg::word_t   rd_bits
);

   // pair lines per column
   localparam int PAIRS = `LAMB_DEPTH / 2;

   // --------------------------------------------------
   // columns
   // --------------------------------------------------

   // column b stores bit b of every entry
   for (genvar b = 0; b < `LAMB_WIDTH; b++) begin : g_col
      logic [PAIRS-1:0] col_dx;

      // only one entry is written at a time, so every pair line
      // of the column carries the same bit
      assign col_dx = {PAIRS{wr_dx[b]}};

      latchblk #(
         .DEPTH (`LAMB_DEPTH)
      ) u_col (
         .ck   (wr_ck),
         .ckb  (wr_ckb),
         .rwl  (rd_rwl),
         .rwlb (rd_rwlb),
         .dx   (col_dx),
         .z    (rd_z),
         .y    (rd_bits[b])
      );
   end

   // the read strobes select a whole row across all columns,
   // so rd_bits is the head entry whenever rd_z is low

endmodule

// ==== src/lamb_cfg.svh ====
// --------------------------------------------------
// lamb configuration
// sizes of the latch-array FIFO and the number of
// receiver credits granted after reset
// --------------------------------------------------

`ifndef LAMB_CFG_SVH
`define LAMB_CFG_SVH

// number of entries, kept even since each data line feeds a pair of entries
`define LAMB_DEPTH 8

// bits per stored word
`define LAMB_WIDTH 16

// depth of the receiver input queue
`define LAMB_OUT_CREDITS 4

`endif

// ==== src/lamb_fifo.sv ====
// --------------------------------------------------
// lamb fifo
// latch-array FIFO with credit flow control on both
// sides, joining write control, array and read control
// --------------------------------------------------

`timescale 1ns/10ps

module lamb_fifo (
   input  logic            ck,
   input  logic            rst_n,
   // sender side
   input  logic            in_valid,
   input  lamb_pkg::word_t in_data,
   output logic            in_credit,
   // receiver side
   output logic            out_valid,
   output lamb_pkg::word_t out_data,
   input  logic            out_credit
);

   import lamb_pkg::*;

   // --------------------------------------------------
   // internal wires
   // --------------------------------------------------

   // write strobes and inverted data into the array
   strobe_t wr_ck;
   strobe_t wr_ckb;
   word_t   wr_dx;

   // read strobes, output force and read word
   strobe_t rd_rwl;
   strobe_t rd_rwlb;
   logic    rd_z;
   word_t   rd_bits;

   // occupancy exchange between the two control blocks
   logic    entry_freed;
   cnt_t    count;

   // --------------------------------------------------
   // write control
   // --------------------------------------------------

   // the count already carries the added entry, so the pulse itself has no load here
   lamb_wr_ctrl u_wr (
      .ck          (ck),
      .rst_n       (rst_n),
      .in_valid    (in_valid),
      .in_data     (in_data),
      .entry_freed (entry_freed),
      .wr_ck       (wr_ck),
      .wr_ckb      (wr_ckb),
      .wr_dx       (wr_dx),
      .entry_added (),
      .count       (count)
   );

   // --------------------------------------------------
   // latch array
   // --------------------------------------------------

   lamb_array u_array (
      .wr_ck   (wr_ck),
      .wr_ckb  (wr_ckb),
      .rd_rwl  (rd_rwl),
      .rd_rwlb (rd_rwlb),
      .wr_dx   (wr_dx),
      .rd_z    (rd_z),
      .rd_bits (rd_bits)
   );

   // --------------------------------------------------
   // read control
   // --------------------------------------------------

   lamb_rd_ctrl u_rd (
      .ck          (ck),
      .rst_n       (rst_n),
      .count       (count),
      .rd_bits     (rd_bits),
      .out_credit  (out_credit),
      .rd_rwl      (rd_rwl),
      .rd_rwlb     (rd_rwlb),
      .rd_z        (rd_z),
      .out_valid   (out_valid),
      .out_data    (out_data),
      .entry_freed (entry_freed),
      .in_credit   (in_credit)
   );

endmodule

// ==== src/lamb_pkg.sv ====
// --------------------------------------------------
// lamb package
// pointer, count, word and strobe types plus the
// pointer helpers shared by both control blocks
// --------------------------------------------------

`include "lamb_cfg.svh"

package lamb_pkg;

   localparam int PTR_W = $clog2(`LAMB_DEPTH);

   // entry index into the latch array
   typedef logic [PTR_W-1:0] ptr_t;
   // occupancy or credit count, one bit wider so a full buffer fits
   typedef logic [PTR_W:0] cnt_t;
   // one stored word
   typedef logic [`LAMB_WIDTH-1:0] word_t;
   // one strobe bit per entry
   typedef logic [`LAMB_DEPTH-1:0] strobe_t;

   // next entry index, wrapping at the last entry so odd depths of two work too
   function automatic ptr_t ptr_next(input ptr_t p);
      return (p == ptr_t'(`LAMB_DEPTH - 1)) ? '0 : p + ptr_t'(1);
   endfunction

   // one-hot select of a single entry
   function automatic strobe_t entry_sel(input ptr_t p);
      return strobe_t'(1) << p;
   endfunction

endpackage

// ==== src/lamb_rd_ctrl.sv ====
// --------------------------------------------------
// lamb read control
// reads the head entry while data and a receiver
// credit are held, registers the word and returns
// one sender credit per freed entry
// --------------------------------------------------

`timescale 1ns/10ps

`include "lamb_cfg.svh"

module lamb_rd_ctrl (
   input  logic              ck,
   input  logic              rst_n,
   // stored entries from the write side
   input  lamb_pkg::cnt_t    count,
   // head word from the array
   input  lamb_pkg::word_t   rd_bits,
   // one pulse per word the receiver consumed
   input  logic              out_credit,
   // read strobe pair and output force into the array
   output lamb_pkg::strobe_t rd_rwl,
   output lamb_pkg::strobe_t rd_rwlb,
   output logic              rd_z,
   // receiver side
   output logic              out_valid,
   output lamb_pkg::word_t   out_data,
   // head entry is taken at the coming edge
   output logic              entry_freed,
   // sender credit return
   output logic              in_credit
);

   import lamb_pkg::*;

   ptr_t  head_q;
   cnt_t  credit_q;
   logic  valid_q;
   word_t data_q;
   logic  rd_go;

   // --------------------------------------------------
   // read decision
   // --------------------------------------------------

   // a read needs a stored entry and room in the receiver queue
   assign rd_go = (count != '0) && (credit_q != '0);

   // drive the head row of the array for the whole cycle
   assign rd_rwl  = rd_go ? entry_sel(head_q) : '0;
   assign rd_rwlb = ~rd_rwl;
   assign rd_z    = ~rd_go;

   // the write side lowers its count at the same edge as the capture
   assign entry_freed = rd_go;

   // --------------------------------------------------
   // head pointer, credits and output valid
   // --------------------------------------------------

   always_ff @(posedge ck) begin
      if (!rst_n) begin
         head_q   <= '0;
         credit_q <= cnt_t'(`LAMB_OUT_CREDITS);
         valid_q  <= 1'b0;
      end else begin
         valid_q <= rd_go;
         if (rd_go) begin
            head_q <= ptr_next(head_q);
         end
         // a spent and a returned credit in one cycle cancel out
         credit_q <= credit_q - cnt_t'(rd_go) + cnt_t'(out_credit);
      end
   end

   // output word register
   always_ff @(posedge ck) begin
      if (rd_go) begin
         data_q <= rd_bits;
      end
   end

   assign out_valid = valid_q;
   assign out_data  = data_q;

   // the freed entry goes back to the sender in the out_valid cycle
   assign in_credit = valid_q;

endmodule

// ==== src/lamb_wr_ctrl.sv ====
// --------------------------------------------------
// lamb write control
// registers accepted words, opens the tail entry's
// strobes in the low clock phase and keeps the count
// --------------------------------------------------

`timescale 1ns/10ps

module lamb_wr_ctrl (
   input  logic              ck,
   input  logic              rst_n,
   // sender side
   input  logic              in_valid,
   input  lamb_pkg::word_t   in_data,
   // one pulse per entry taken by the read side
   input  logic              entry_freed,
   // write strobe pair and inverted data into the array
   output lamb_pkg::strobe_t wr_ck,
   output lamb_pkg::strobe_t wr_ckb,
   output lamb_pkg::word_t   wr_dx,
   // pulses in the cycle after a write closed
   output logic              entry_added,
   // stored entries visible to the read side
   output lamb_pkg::cnt_t    count
);

   import lamb_pkg::*;

   logic  acc_vld_q;
   word_t acc_data_q;
   logic  wr_en_q;
   word_t wr_dx_q;
   ptr_t  tail_q;
   logic  added_q;
   cnt_t  count_q;
   logic  wr_open;

   // --------------------------------------------------
   // control pipeline
   // --------------------------------------------------

   // accept at E, strobe in the second half of E+1, closed at E+2
   always_ff @(posedge ck) begin
      if (!rst_n) begin
         acc_vld_q <= 1'b0;
         wr_en_q   <= 1'b0;
         added_q   <= 1'b0;
         tail_q    <= '0;
         count_q   <= '0;
      end else begin
         acc_vld_q <= in_valid;
         wr_en_q   <= acc_vld_q;
         added_q   <= wr_en_q;
         // the tail moves at the edge that closes the write
         if (wr_en_q) begin
            tail_q <= ptr_next(tail_q);
         end
         count_q <= count_q + cnt_t'(added_q) - cnt_t'(entry_freed);
      end
   end

   // word registers, the second one holds the data steady while the latch is open
   always_ff @(posedge ck) begin
      if (in_valid) begin
         acc_data_q <= in_data;
      end
      if (acc_vld_q) begin
         wr_dx_q <= ~acc_data_q;
      end
   end

   // --------------------------------------------------
   // strobes and outputs
   // --------------------------------------------------

   // open only in the low phase so the latch closes on the rising edge
   assign wr_open = wr_en_q & ~ck;
   assign wr_ck   = wr_open ? entry_sel(tail_q) : '0;
   assign wr_ckb  = ~wr_ck;
   assign wr_dx   = wr_dx_q;

   assign entry_added = added_q;

   // a just-closed entry is readable in the same cycle as its entry_added pulse
   assign count = count_q + cnt_t'(added_q);

endmodule

// ==== src/latchblk.sv ====
// --------------------------------------------------
// latchblk
// one bit column of transparent latches, with a data
// line per entry pair, complementary write and read
// strobes and a shared read output
// --------------------------------------------------

`timescale 1ns/10ps

module latchblk #(
   parameter int DEPTH = 4
) (
   // write strobe, active high
   input  logic [DEPTH-1:0]   ck,
   // write strobe complement, active low
   input  logic [DEPTH-1:0]   ckb,
   // read strobe, active high
   input  logic [DEPTH-1:0]   rwl,
   // read strobe complement, active low
   input  logic [DEPTH-1:0]   rwlb,
   // inverted data, one line per pair of entries
   input  logic [DEPTH/2-1:0] dx,
   // forces the shared output low
   input  logic               z,
   // shared read output
   output logic               y
);

   // pair lines derived from the column depth
   localparam int PAIRS = DEPTH / 2;

   logic [PAIRS-1:0] d;
   logic [DEPTH-1:0] cken;
   logic [DEPTH-1:0] rwlen;
   logic [DEPTH-1:0] dout;

   // --------------------------------------------------
   // write side
   // --------------------------------------------------

   // the data lines arrive inverted and are restored here
   assign d = ~dx;

   // a latch only opens when the strobe and its complement agree
   assign cken = ck & ~ckb;

   for (genvar i = 0; i < DEPTH; i++) begin : g_entry
      logic q;

      // entries 2k and 2k+1 both listen to data line k
      always_latch begin
         if (cken[i]) begin
            q <= d[i/2];
         end
      end

      // each entry only reaches the output while its read strobe is on
      assign dout[i] = rwlen[i] & q;
   end

   // --------------------------------------------------
   // read side
   // --------------------------------------------------

   // read strobes are qualified the same way as the write strobes
   assign rwlen = rwl & ~rwlb;

   // wired-or of the selected entries, pulled low while nothing is read
   assign y = ~z & (|dout);

endmodule
